// File: axi_bus_pkg.sv
package axi_bus_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   // one strobe bit per data byte.
   localparam int STRB_W = DATA_W / 8;
   localparam int LEN_W = 8;
   localparam int ID_W = 2;

   // memory depth in words.
   localparam int MEM_DEPTH = 256;
   localparam int MEM_AW = $clog2(MEM_DEPTH);
   // byte address bits below the word index.
   localparam int ADDR_LSB = $clog2(STRB_W);

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   // beats minus one.
   typedef logic [LEN_W-1:0] len_t;
   typedef logic [ID_W-1:0] id_t;
   typedef logic [MEM_AW-1:0] mem_addr_t;

endpackage

// File: axi_ctrl_pkg.sv
package axi_ctrl_pkg;

   typedef enum logic {
      CMD_WRITE,
      CMD_READ
   } cmd_op_e;

   typedef enum logic [2:0] {
      M_IDLE,
      M_WR_ADDR,
      M_WR_DATA,
      M_WR_WAIT,
      M_RD_ADDR,
      M_RD_DATA
   } master_state_e;

   typedef enum logic [1:0] {
      S_IDLE,
      S_WR_BURST,
      S_WR_BACK,
      S_RD_BURST
   } slave_state_e;

endpackage

// File: axi_bus_if.sv
`timescale 1ns/1ps

interface axi_bus_if;

   // write address.
   axi_bus_pkg::addr_t wr_addr;
   axi_bus_pkg::len_t  wr_len;
   axi_bus_pkg::id_t   wr_id;
   logic               wr_addr_valid;
   logic               wr_addr_ready;

   // write data.
   axi_bus_pkg::data_t wr_data;
   axi_bus_pkg::strb_t wr_strb;
   logic               wr_data_last;
   logic               wr_data_valid;
   logic               wr_data_ready;

   // write completion, a single pulse with no ready.
   axi_bus_pkg::id_t   wr_back_id;
   logic               wr_back_valid;

   // read address.
   axi_bus_pkg::addr_t rd_addr;
   axi_bus_pkg::len_t  rd_len;
   axi_bus_pkg::id_t   rd_id;
   logic               rd_addr_valid;
   logic               rd_addr_ready;

   // read data.
   axi_bus_pkg::data_t rd_data;
   logic               rd_data_last;
   axi_bus_pkg::id_t   rd_back_id;
   logic               rd_data_valid;
   logic               rd_data_ready;

   modport master (
      output wr_addr, wr_len, wr_id, wr_addr_valid,
      input  wr_addr_ready,
      output wr_data, wr_strb, wr_data_last, wr_data_valid,
      input  wr_data_ready,
      input  wr_back_id, wr_back_valid,
      output rd_addr, rd_len, rd_id, rd_addr_valid,
      input  rd_addr_ready,
      input  rd_data, rd_data_last, rd_back_id, rd_data_valid,
      output rd_data_ready
   );

   modport slave (
      input  wr_addr, wr_len, wr_id, wr_addr_valid,
      output wr_addr_ready,
      input  wr_data, wr_strb, wr_data_last, wr_data_valid,
      output wr_data_ready,
      output wr_back_id, wr_back_valid,
      input  rd_addr, rd_len, rd_id, rd_addr_valid,
      output rd_addr_ready,
      output rd_data, rd_data_last, rd_back_id, rd_data_valid,
      input  rd_data_ready
   );

endinterface

// File: axi_master.sv
`timescale 1ns/1ps

module axi_master (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  axi_ctrl_pkg::cmd_op_e cmd_op,
   input  axi_bus_pkg::addr_t    cmd_addr,
   input  axi_bus_pkg::len_t     cmd_len,
   input  axi_bus_pkg::id_t      cmd_id,
   input  logic                  wdata_valid,
   output logic                  wdata_ready,
   input  axi_bus_pkg::data_t    wdata,
   input  axi_bus_pkg::strb_t    wstrb,
   output logic                  rdata_valid,
   input  logic                  rdata_ready,
   output axi_bus_pkg::data_t    rdata,
   output logic                  rdata_last,
   output axi_bus_pkg::id_t      rdata_id,
   output logic                  wresp_valid,
   output axi_bus_pkg::id_t      wresp_id,
   axi_bus_if.master             bus
);

   axi_ctrl_pkg::master_state_e state;
   axi_bus_pkg::addr_t          addr_q;
   axi_bus_pkg::len_t           len_q;
   axi_bus_pkg::id_t            id_q;
   axi_bus_pkg::len_t           beat_cnt;
   logic                        wr_beat;
   logic                        rd_beat;

   assign cmd_ready = (state == axi_ctrl_pkg::M_IDLE);

   // both address channels show the latched command.
   assign bus.wr_addr       = addr_q;
   assign bus.wr_len        = len_q;
   assign bus.wr_id         = id_q;
   assign bus.wr_addr_valid = (state == axi_ctrl_pkg::M_WR_ADDR);
   assign bus.rd_addr       = addr_q;
   assign bus.rd_len        = len_q;
   assign bus.rd_id         = id_q;
   assign bus.rd_addr_valid = (state == axi_ctrl_pkg::M_RD_ADDR);

   // write beats go straight from the user stream.
   assign bus.wr_data       = wdata;
   assign bus.wr_strb       = wstrb;
   assign bus.wr_data_last  = (beat_cnt == len_q);
   assign bus.wr_data_valid = (state == axi_ctrl_pkg::M_WR_DATA) && wdata_valid;
   assign wdata_ready       = (state == axi_ctrl_pkg::M_WR_DATA) && bus.wr_data_ready;
   assign wr_beat           = bus.wr_data_valid && bus.wr_data_ready;

   // read beats come straight back to the user.
   assign rdata             = bus.rd_data;
   assign rdata_last        = bus.rd_data_last;
   assign rdata_id          = bus.rd_back_id;
   assign rdata_valid       = (state == axi_ctrl_pkg::M_RD_DATA) && bus.rd_data_valid;
   assign bus.rd_data_ready = (state == axi_ctrl_pkg::M_RD_DATA) && rdata_ready;
   assign rd_beat           = rdata_valid && rdata_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= axi_ctrl_pkg::M_IDLE;
         beat_cnt    <= '0;
         wresp_valid <= 1'b0;
      end else begin
         wresp_valid <= 1'b0;
         case (state)
            axi_ctrl_pkg::M_IDLE: begin
               if (cmd_valid) begin
                  beat_cnt <= '0;
                  state    <= (cmd_op == axi_ctrl_pkg::CMD_WRITE) ?
                              axi_ctrl_pkg::M_WR_ADDR : axi_ctrl_pkg::M_RD_ADDR;
               end
            end
            axi_ctrl_pkg::M_WR_ADDR: begin
               if (bus.wr_addr_ready) begin
                  state <= axi_ctrl_pkg::M_WR_DATA;
               end
            end
            axi_ctrl_pkg::M_WR_DATA: begin
               if (wr_beat) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (bus.wr_data_last) begin
                     state <= axi_ctrl_pkg::M_WR_WAIT;
                  end
               end
            end
            axi_ctrl_pkg::M_WR_WAIT: begin
               if (bus.wr_back_valid) begin
                  wresp_valid <= 1'b1;
                  state       <= axi_ctrl_pkg::M_IDLE;
               end
            end
            axi_ctrl_pkg::M_RD_ADDR: begin
               if (bus.rd_addr_ready) begin
                  state <= axi_ctrl_pkg::M_RD_DATA;
               end
            end
            axi_ctrl_pkg::M_RD_DATA: begin
               if (rd_beat && bus.rd_data_last) begin
                  state <= axi_ctrl_pkg::M_IDLE;
               end
            end
            default: state <= axi_ctrl_pkg::M_IDLE;
         endcase
      end
   end

   // command fields and the completion id.
   always_ff @(posedge clk) begin
      if (cmd_valid && cmd_ready) begin
         addr_q <= cmd_addr;
         len_q  <= cmd_len;
         id_q   <= cmd_id;
      end
      if (bus.wr_back_valid) begin
         wresp_id <= bus.wr_back_id;
      end
   end

endmodule

// File: axi_slave_mem.sv
`timescale 1ns/1ps

module axi_slave_mem (
   input  logic     clk,
   input  logic     rst,
   axi_bus_if.slave bus
);

   axi_bus_pkg::data_t         mem [axi_bus_pkg::MEM_DEPTH];
   axi_ctrl_pkg::slave_state_e state;
   axi_bus_pkg::mem_addr_t     word_addr;
   axi_bus_pkg::len_t          len_q;
   axi_bus_pkg::len_t          beat_cnt;
   axi_bus_pkg::id_t           id_q;
   logic                       wr_addr_hs;
   logic                       rd_addr_hs;
   logic                       wr_beat;
   logic                       rd_beat;

   // writes win when both address channels arrive together.
   assign bus.wr_addr_ready = (state == axi_ctrl_pkg::S_IDLE);
   assign bus.rd_addr_ready = (state == axi_ctrl_pkg::S_IDLE) && !bus.wr_addr_valid;
   assign wr_addr_hs        = bus.wr_addr_valid && bus.wr_addr_ready;
   assign rd_addr_hs        = bus.rd_addr_valid && bus.rd_addr_ready;

   assign bus.wr_data_ready = (state == axi_ctrl_pkg::S_WR_BURST);
   assign wr_beat           = bus.wr_data_valid && bus.wr_data_ready;

   assign bus.wr_back_valid = (state == axi_ctrl_pkg::S_WR_BACK);
   assign bus.wr_back_id    = id_q;

   // read word is looked up straight from the current address.
   assign bus.rd_data_valid = (state == axi_ctrl_pkg::S_RD_BURST);
   assign bus.rd_data       = mem[word_addr];
   assign bus.rd_data_last  = (beat_cnt == len_q);
   assign bus.rd_back_id    = id_q;
   assign rd_beat           = bus.rd_data_valid && bus.rd_data_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= axi_ctrl_pkg::S_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            axi_ctrl_pkg::S_IDLE: begin
               beat_cnt <= '0;
               if (wr_addr_hs) begin
                  state <= axi_ctrl_pkg::S_WR_BURST;
               end else if (rd_addr_hs) begin
                  state <= axi_ctrl_pkg::S_RD_BURST;
               end
            end
            axi_ctrl_pkg::S_WR_BURST: begin
               if (wr_beat) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (bus.wr_data_last) begin
                     state <= axi_ctrl_pkg::S_WR_BACK;
                  end
               end
            end
            axi_ctrl_pkg::S_WR_BACK: begin
               state <= axi_ctrl_pkg::S_IDLE;
            end
            axi_ctrl_pkg::S_RD_BURST: begin
               if (rd_beat) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (bus.rd_data_last) begin
                     state <= axi_ctrl_pkg::S_IDLE;
                  end
               end
            end
            default: state <= axi_ctrl_pkg::S_IDLE;
         endcase
      end
   end

   // burst address, length and id.
   always_ff @(posedge clk) begin
      if (wr_addr_hs) begin
         word_addr <= bus.wr_addr[axi_bus_pkg::ADDR_LSB +: axi_bus_pkg::MEM_AW];
         len_q     <= bus.wr_len;
         id_q      <= bus.wr_id;
      end else if (rd_addr_hs) begin
         word_addr <= bus.rd_addr[axi_bus_pkg::ADDR_LSB +: axi_bus_pkg::MEM_AW];
         len_q     <= bus.rd_len;
         id_q      <= bus.rd_id;
      end else if (wr_beat || rd_beat) begin
         // wraps at the top of memory.
         word_addr <= word_addr + 1'b1;
      end
   end

   // byte-enabled write.
   always_ff @(posedge clk) begin
      if (wr_beat) begin
         for (int b = 0; b < axi_bus_pkg::STRB_W; b++) begin
            if (bus.wr_strb[b]) begin
               mem[word_addr][8*b +: 8] <= bus.wr_data[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: axi_mem_system.sv
`timescale 1ns/1ps

module axi_mem_system (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  axi_ctrl_pkg::cmd_op_e cmd_op,
   input  axi_bus_pkg::addr_t    cmd_addr,
   input  axi_bus_pkg::len_t     cmd_len,
   input  axi_bus_pkg::id_t      cmd_id,
   input  logic                  wdata_valid,
   output logic                  wdata_ready,
   input  axi_bus_pkg::data_t    wdata,
   input  axi_bus_pkg::strb_t    wstrb,
   output logic                  rdata_valid,
   input  logic                  rdata_ready,
   output axi_bus_pkg::data_t    rdata,
   output logic                  rdata_last,
   output axi_bus_pkg::id_t      rdata_id,
   output logic                  wresp_valid,
   output axi_bus_pkg::id_t      wresp_id
);

   axi_bus_if bus ();

   axi_master master_inst (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd_op      (cmd_op),
      .cmd_addr    (cmd_addr),
      .cmd_len     (cmd_len),
      .cmd_id      (cmd_id),
      .wdata_valid (wdata_valid),
      .wdata_ready (wdata_ready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .rdata_valid (rdata_valid),
      .rdata_ready (rdata_ready),
      .rdata       (rdata),
      .rdata_last  (rdata_last),
      .rdata_id    (rdata_id),
      .wresp_valid (wresp_valid),
      .wresp_id    (wresp_id),
      .bus         (bus.master)
   );

   axi_slave_mem slave_inst (
      .clk (clk),
      .rst (rst),
      .bus (bus.slave)
   );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   localparam int HALF_PERIOD = 10;
   localparam int RESET_CYCLES = 8;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // release just after the last reset edge.
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;
   end

endmodule

// File: axi_mem_system_tb.sv
`timescale 1ns/1ps

module axi_mem_system_tb;

   // beats and commands over all tests, used for the watchdog.
   localparam int TOTAL_BEATS = 985;
   localparam int TOTAL_CMDS = 59;
   localparam int WATCHDOG_NS = (TOTAL_BEATS + 20 * TOTAL_CMDS) * 4 * 20;

   logic                  clk;
   logic                  rst;
   logic                  cmd_valid;
   logic                  cmd_ready;
   axi_ctrl_pkg::cmd_op_e cmd_op;
   axi_bus_pkg::addr_t    cmd_addr;
   axi_bus_pkg::len_t     cmd_len;
   axi_bus_pkg::id_t      cmd_id;
   logic                  wdata_valid;
   logic                  wdata_ready;
   axi_bus_pkg::data_t    wdata;
   axi_bus_pkg::strb_t    wstrb;
   logic                  rdata_valid;
   logic                  rdata_ready;
   axi_bus_pkg::data_t    rdata;
   logic                  rdata_last;
   axi_bus_pkg::id_t      rdata_id;
   logic                  wresp_valid;
   axi_bus_pkg::id_t      wresp_id;

   integer             seed;
   axi_bus_pkg::data_t ref_mem [axi_bus_pkg::MEM_DEPTH];
   axi_bus_pkg::data_t exp_data_q [$];
   axi_bus_pkg::id_t   exp_id_q [$];
   logic               exp_last_q [$];
   axi_bus_pkg::id_t   wr_id_exp;
   logic               wr_pending = 1'b0;
   int                 mismatch_count = 0;
   int                 other_fails = 0;
   int                 rd_count = 0;
   int                 wresp_count = 0;

   tb_clock_gen clock_inst (
      .clk (clk),
      .rst (rst)
   );

   axi_mem_system UUT (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .cmd_op      (cmd_op),
      .cmd_addr    (cmd_addr),
      .cmd_len     (cmd_len),
      .cmd_id      (cmd_id),
      .wdata_valid (wdata_valid),
      .wdata_ready (wdata_ready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .rdata_valid (rdata_valid),
      .rdata_ready (rdata_ready),
      .rdata       (rdata),
      .rdata_last  (rdata_last),
      .rdata_id    (rdata_id),
      .wresp_valid (wresp_valid),
      .wresp_id    (wresp_id)
   );

   // expected word after one write beat.
   function automatic axi_bus_pkg::data_t merge_bytes(input axi_bus_pkg::data_t old_word,
                                                      input axi_bus_pkg::data_t new_word,
                                                      input axi_bus_pkg::strb_t strb);
      axi_bus_pkg::data_t result;
      int                 b;
      result = old_word;
      for (b = 0; b < axi_bus_pkg::STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   function automatic int word_index(input axi_bus_pkg::addr_t addr);
      return int'((addr >> 2) % axi_bus_pkg::MEM_DEPTH);
   endfunction

   function automatic axi_bus_pkg::data_t fill_word(input int w);
      logic [7:0] a;
      a = w[7:0];
      return {a, ~a, a ^ 8'h5a, 8'hc3};
   endfunction

   function automatic logic [31:0] rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic logic chance(input int pct);
      return int'(rand_word() % 32'd100) < pct;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp);
         mismatch_count++;
      end
   endtask

   // starts and ends 2 ns after a rising edge.
   task automatic issue_cmd(input axi_ctrl_pkg::cmd_op_e op, input axi_bus_pkg::addr_t addr,
                            input axi_bus_pkg::len_t len, input axi_bus_pkg::id_t id);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_len   = len;
      cmd_id    = id;
      @(negedge clk);
      while (!cmd_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
   endtask

   task automatic write_burst(input axi_bus_pkg::addr_t addr, input axi_bus_pkg::len_t len,
                              input axi_bus_pkg::id_t id, input axi_bus_pkg::strb_t strb,
                              input bit rand_strb, input int gap_pct, input bit fill);
      int                 w;
      int                 n;
      int                 beat;
      int                 k;
      int                 start;
      logic [31:0]        r;
      axi_bus_pkg::data_t d;
      axi_bus_pkg::strb_t s;
      n = int'(len) + 1;
      w = word_index(addr);
      start = wresp_count;
      wr_id_exp = id;
      wr_pending = 1'b1;
      issue_cmd(axi_ctrl_pkg::CMD_WRITE, addr, len, id);
      beat = 0;
      while (beat < n) begin
         d = fill ? fill_word(w) : rand_word();
         r = rand_word();
         s = rand_strb ? r[axi_bus_pkg::STRB_W-1:0] : strb;
         if (chance(gap_pct)) begin
            wdata_valid = 1'b0;
            @(posedge clk);
            #2;
         end
         wdata       = d;
         wstrb       = s;
         wdata_valid = 1'b1;
         @(negedge clk);
         while (!wdata_ready) begin
            @(negedge clk);
         end
         ref_mem[w] = merge_bytes(ref_mem[w], d, s);
         w = (w + 1) % axi_bus_pkg::MEM_DEPTH;
         beat++;
         @(posedge clk);
         #2;
      end
      wdata_valid = 1'b0;
      k = 0;
      while (wresp_count == start && k < 20) begin
         @(posedge clk);
         #2;
         k++;
      end
      if (wresp_count == start) begin
         $display("Write burst id %0d at %h never got its completion", id, addr);
         other_fails++;
      end
   endtask

   task automatic read_burst(input axi_bus_pkg::addr_t addr, input axi_bus_pkg::len_t len,
                             input axi_bus_pkg::id_t id, input int bp_pct);
      int w;
      int n;
      int k;
      int start;
      n = int'(len) + 1;
      w = word_index(addr);
      for (k = 0; k < n; k++) begin
         exp_data_q.push_back(ref_mem[w]);
         exp_id_q.push_back(id);
         exp_last_q.push_back(k == n - 1);
         w = (w + 1) % axi_bus_pkg::MEM_DEPTH;
      end
      start = rd_count;
      issue_cmd(axi_ctrl_pkg::CMD_READ, addr, len, id);
      k = 0;
      while (rd_count - start < n && k < 20 * n + 20) begin
         rdata_ready = !chance(bp_pct);
         @(posedge clk);
         #2;
         k++;
      end
      rdata_ready = 1'b1;
      if (rd_count - start < n) begin
         $display("Read burst id %0d at %h ended with %0d of %0d beats",
                  id, addr, rd_count - start, n);
         other_fails++;
      end
   endtask

   // outputs are settled at the falling edge.
   always @(negedge clk) begin : compare
      axi_bus_pkg::data_t e_data;
      axi_bus_pkg::id_t   e_id;
      logic               e_last;
      if (rst === 1'b0) begin
         if (rdata_valid && rdata_ready) begin
            if (exp_data_q.size() == 0) begin
               $display("Read beat at %0t ns arrived with no read outstanding", $time);
               other_fails++;
            end else begin
               e_data = exp_data_q.pop_front();
               e_id   = exp_id_q.pop_front();
               e_last = exp_last_q.pop_front();
               check_value("rdata", rdata, e_data);
               check_value("rdata_id", 32'(rdata_id), 32'(e_id));
               check_value("rdata_last", 32'(rdata_last), 32'(e_last));
            end
            rd_count++;
         end
         if (wresp_valid) begin
            if (!wr_pending) begin
               $display("Extra write completion at %0t ns with id %0d", $time, wresp_id);
               other_fails++;
            end else begin
               check_value("wresp_id", 32'(wresp_id), 32'(wr_id_exp));
               wr_pending = 1'b0;
            end
            wresp_count++;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog ended the run after %0d ns, tests unfinished", WATCHDOG_NS);
      $display("Test failures found");
      $finish;
   end

   initial begin : stimulus
      int                    i;
      logic [31:0]           r;
      axi_bus_pkg::addr_t    addr;
      axi_ctrl_pkg::cmd_op_e op;
      seed        = 32'h72a5;
      cmd_valid   = 1'b0;
      cmd_op      = axi_ctrl_pkg::CMD_WRITE;
      cmd_addr    = '0;
      cmd_len     = '0;
      cmd_id      = '0;
      wdata_valid = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      rdata_ready = 1'b1;
      for (i = 0; i < axi_bus_pkg::MEM_DEPTH; i++) begin
         ref_mem[i] = '0;
      end
      @(negedge rst);

      // whole memory gets a known pattern first.
      write_burst(32'h0000_0000, 8'd255, 2'd0, 4'hf, 1'b0, 0, 1'b1);

      write_burst(32'h0000_0100, 8'd3, 2'd1, 4'hf, 1'b0, 0, 1'b0);
      read_burst(32'h0000_0100, 8'd3, 2'd2, 0);

      // bytes 0 and 2 only.
      write_burst(32'h0000_0200, 8'd1, 2'd3, 4'b0101, 1'b0, 0, 1'b0);
      read_burst(32'h0000_0200, 8'd1, 2'd0, 0);

      read_burst(32'h0000_0300, 8'd0, 2'd1, 0);
      write_burst(32'h0000_0304, 8'd0, 2'd2, 4'hf, 1'b0, 0, 1'b0);
      read_burst(32'h0000_0304, 8'd0, 2'd3, 0);

      // words 254, 255, 0, 1.
      write_burst(32'h0000_03f8, 8'd3, 2'd0, 4'hf, 1'b0, 0, 1'b0);
      read_burst(32'h0000_03f8, 8'd3, 2'd1, 0);
      read_burst(32'h0000_0000, 8'd1, 2'd2, 0);

      for (i = 0; i < 4; i++) begin
         addr = rand_word();
         r = rand_word();
         write_burst(addr, 8'd7, r[1:0], 4'hf, 1'b0, 50, 1'b0);
         read_burst(addr, 8'd7, r[3:2], 50);
      end

      for (i = 0; i < 40; i++) begin
         r = rand_word();
         addr = rand_word();
         op = r[0] ? axi_ctrl_pkg::CMD_READ : axi_ctrl_pkg::CMD_WRITE;
         if (op == axi_ctrl_pkg::CMD_WRITE) begin
            write_burst(addr, {4'b0000, r[11:8]}, r[5:4], 4'hf, 1'b1, 25, 1'b0);
         end else begin
            read_burst(addr, {4'b0000, r[11:8]}, r[5:4], 25);
         end
      end

      repeat (5) @(posedge clk);
      if (exp_data_q.size() != 0) begin
         $display("%0d expected read beats never arrived", exp_data_q.size());
         other_fails++;
      end
      $display("mismatches %0d, other failures %0d, read beats %0d, write completions %0d",
               mismatch_count, other_fails, rd_count, wresp_count);
      if (mismatch_count == 0 && other_fails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: axi_mem_system.f
axi_bus_pkg.sv
axi_ctrl_pkg.sv
axi_bus_if.sv
axi_master.sv
axi_slave_mem.sv
axi_mem_system.sv
tb_clock_gen.sv
axi_mem_system_tb.sv

// File: Makefile
TOP = axi_mem_system_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --timescale 1ns/1ps --top-module $(TOP) \
		-f axi_mem_system.f -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "All tests passed!" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
